// File: design/vision_pkg.sv
package vision_pkg;

    // Frame geometry
    localparam int FRAME_WIDTH  = 320;
    localparam int FRAME_HEIGHT = 240;
    localparam int COL_W        = 9;
    localparam int ROW_W        = 8;
    localparam int COUNT_W      = 18;

    // Register byte offsets
    localparam logic [4:0] REG_CTRL   = 5'h00;
    localparam logic [4:0] REG_COLOR  = 5'h04;
    localparam logic [4:0] REG_ZONES  = 5'h08;
    localparam logic [4:0] REG_THRESH = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;
    localparam logic [4:0] REG_COUNT  = 5'h14;
    localparam logic [4:0] REG_IRQ    = 5'h18;

    localparam logic [COL_W-1:0]   DEF_LEFT_END    = 9'd100;
    localparam logic [COL_W-1:0]   DEF_RIGHT_START = 9'd270;
    localparam logic [COUNT_W-1:0] DEF_THRESHOLD   = COUNT_W'(FRAME_WIDTH * FRAME_HEIGHT / 20);
    localparam logic [3:0]         DEF_RED_MIN     = 4'd12;
    localparam logic [3:0]         DEF_GREEN_MIN   = 4'd4;
    localparam logic [3:0]         DEF_GREEN_MAX   = 4'd9;
    localparam logic [3:0]         DEF_BLUE_MAX    = 4'd3;

    localparam logic [2:0] DIR_NONE   = 3'b000;
    localparam logic [2:0] DIR_LEFT   = 3'b001;
    localparam logic [2:0] DIR_RIGHT  = 3'b010;
    localparam logic [2:0] DIR_CENTER = 3'b011;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    typedef struct packed {
        rgb444_t          rgb;
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
        logic             last; // Final pixel of the frame
    } pixel_beat_t;

    typedef enum logic [1:0] {
        ZONE_LEFT,
        ZONE_CENTER,
        ZONE_RIGHT,
        ZONE_OUT
    } zone_t;

    typedef struct packed {
        logic  is_orange;
        zone_t zone;
        logic  last;
    } class_beat_t;

    // Same layout as REG_COLOR[15:0], red_min in the top nibble
    typedef struct packed {
        logic [3:0] red_min;
        logic [3:0] green_min;
        logic [3:0] green_max;
        logic [3:0] blue_max;
    } color_cfg_t;

    typedef struct packed {
        color_cfg_t         color;
        logic [COL_W-1:0]   left_end;
        logic [COL_W-1:0]   right_start;
        logic [COUNT_W-1:0] threshold;
    } detect_cfg_t;

    typedef struct packed {
        logic [COUNT_W-1:0] left;
        logic [COUNT_W-1:0] center;
        logic [COUNT_W-1:0] right;
        logic [COUNT_W-1:0] total;
    } frame_stats_t;

    typedef struct packed {
        logic               detected;
        logic [2:0]         direction;
        logic [COUNT_W-1:0] orange_count;
    } detect_result_t;

endpackage

// File: design/frame_timing.sv
`timescale 1ns/100ps

module frame_timing
    import vision_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  rgb444_t     pixel,
    input  logic        href,
    input  logic        vsync,
    output pixel_beat_t beat,
    output logic        beat_valid
);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             href_d;
    logic             in_frame;

    assign in_frame = (col < COL_W'(FRAME_WIDTH)) && (row < ROW_W'(FRAME_HEIGHT));

    // Position counters
    always_ff @(posedge clk) begin
        if (rst) begin
            col    <= '0;
            row    <= '0;
            href_d <= 1'b0;
        end else begin
            href_d <= href;
            if (vsync) begin
                col <= '0; // New frame
                row <= '0;
            end else if (href) begin
                if (col != COL_W'(FRAME_WIDTH))
                    col <= col + 1'b1; // Hold at the width on over-long lines
            end else begin
                col <= '0;
                if (href_d && row != ROW_W'(FRAME_HEIGHT))
                    row <= row + 1'b1; // Falling edge of href ends the line
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            beat_valid <= 1'b0;
        else
            beat_valid <= enable && href && !vsync && in_frame;
    end

    always_ff @(posedge clk) begin
        beat.rgb  <= pixel;
        beat.col  <= col;
        beat.row  <= row;
        beat.last <= (col == COL_W'(FRAME_WIDTH - 1)) && (row == ROW_W'(FRAME_HEIGHT - 1));
    end

endmodule

// File: design/pixel_classifier.sv
`timescale 1ns/100ps

module pixel_classifier
    import vision_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  pixel_beat_t beat,
    input  logic        beat_valid,
    input  detect_cfg_t cfg,
    output class_beat_t cls,
    output logic        cls_valid
);

    logic  is_orange;
    zone_t zone;

    // Colour window, all bounds inclusive
    always_comb begin
        is_orange = (beat.rgb.red >= cfg.color.red_min) &&
                    (beat.rgb.green >= cfg.color.green_min) &&
                    (beat.rgb.green <= cfg.color.green_max) &&
                    (beat.rgb.blue <= cfg.color.blue_max);
    end

    // Column zones, checked from the left edge outward
    always_comb begin
        if (beat.col < cfg.left_end)
            zone = ZONE_LEFT;
        else if (beat.col < cfg.right_start)
            zone = ZONE_CENTER;
        else if (beat.col < COL_W'(FRAME_WIDTH))
            zone = ZONE_RIGHT;
        else
            zone = ZONE_OUT;
    end

    always_ff @(posedge clk) begin
        if (rst)
            cls_valid <= 1'b0;
        else
            cls_valid <= beat_valid;
    end

    always_ff @(posedge clk) begin
        cls.is_orange <= is_orange;
        cls.zone      <= zone;
        cls.last      <= beat.last; // Frame end rides along
    end

endmodule

// File: design/zone_accumulator.sv
`timescale 1ns/100ps

module zone_accumulator
    import vision_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  class_beat_t  cls,
    input  logic         cls_valid,
    output frame_stats_t stats,
    output logic         stats_valid
);

    frame_stats_t acc;      // Running counts of the current frame
    frame_stats_t acc_next; // Counts including the incoming beat
    logic         hit;

    always_comb begin
        hit = cls_valid && cls.is_orange && (cls.zone != ZONE_OUT);

        acc_next.left   = acc.left + COUNT_W'(hit && (cls.zone == ZONE_LEFT));
        acc_next.center = acc.center + COUNT_W'(hit && (cls.zone == ZONE_CENTER));
        acc_next.right  = acc.right + COUNT_W'(hit && (cls.zone == ZONE_RIGHT));
        acc_next.total  = acc.total + COUNT_W'(hit);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            stats_valid <= 1'b0;
        end else begin
            stats_valid <= cls_valid && cls.last;
            if (cls_valid) begin
                if (cls.last)
                    acc <= '0; // Start clean for the next frame
                else
                    acc <= acc_next;
            end
        end
    end

    // Snapshot of the finished frame
    always_ff @(posedge clk) begin
        if (cls_valid && cls.last)
            stats <= acc_next;
    end

endmodule

// File: design/steer_decision.sv
`timescale 1ns/100ps

module steer_decision
    import vision_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  frame_stats_t       stats,
    input  logic               stats_valid,
    input  logic [COUNT_W-1:0] threshold,
    output detect_result_t     result,
    output logic               result_valid
);

    logic       detected;
    logic [2:0] direction;

    always_comb begin
        detected  = stats.total > threshold;
        direction = result.direction; // Keep last heading by default
        if (detected) begin
            if (stats.right > stats.left)
                direction = DIR_RIGHT;
            else if (stats.center > stats.left && stats.center > stats.right)
                direction = DIR_CENTER;
            else if (stats.left > stats.right)
                direction = DIR_LEFT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.detected     <= 1'b0;
            result.direction    <= DIR_NONE;
            result.orange_count <= '0;
            result_valid        <= 1'b0;
        end else begin
            result_valid <= stats_valid;
            if (stats_valid) begin
                result.detected     <= detected;
                result.direction    <= direction;
                result.orange_count <= stats.total;
            end
        end
    end

endmodule

// File: design/detect_ctrl.sv
`timescale 1ns/100ps

module detect_ctrl
    import vision_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  detect_result_t result,
    input  logic           result_valid,
    input  logic [4:0]     awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  logic [31:0]    wdata,
    input  logic [3:0]     wstrb,
    input  logic           wvalid,
    output logic           wready,
    output logic [1:0]     bresp,
    output logic           bvalid,
    input  logic           bready,
    input  logic [4:0]     araddr,
    input  logic           arvalid,
    output logic           arready,
    output logic [31:0]    rdata,
    output logic [1:0]     rresp,
    output logic           rvalid,
    input  logic           rready,
    output detect_cfg_t    cfg,
    output logic           enable,
    output logic           irq
);

    detect_result_t status;
    logic [15:0]    frame_cnt;
    logic           irq_pending;
    logic           wr_fire;
    logic           rd_fire;
    logic [31:0]    strb_mask;
    logic [31:0]    wr_word;

    function automatic logic addr_known(input logic [4:0] addr);
        case (addr)
            REG_CTRL, REG_COLOR, REG_ZONES, REG_THRESH,
            REG_STATUS, REG_COUNT, REG_IRQ: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

    // Current register contents as seen on the bus
    function automatic logic [31:0] reg_word(input logic [4:0] addr);
        case (addr)
            REG_CTRL:   return {31'd0, enable};
            REG_COLOR:  return {16'd0, cfg.color};
            REG_ZONES:  return {{(16 - COL_W){1'b0}}, cfg.right_start,
                                {(16 - COL_W){1'b0}}, cfg.left_end};
            REG_THRESH: return {{(32 - COUNT_W){1'b0}}, cfg.threshold};
            REG_STATUS: return {frame_cnt, 12'd0, status.direction, status.detected};
            REG_COUNT:  return {{(32 - COUNT_W){1'b0}}, status.orange_count};
            REG_IRQ:    return {31'd0, irq_pending};
            default:    return 32'd0;
        endcase
    endfunction

    assign wr_fire   = awvalid && wvalid && awready;
    assign rd_fire   = arvalid && arready;
    assign strb_mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
    assign wr_word   = (reg_word(awaddr) & ~strb_mask) | (wdata & strb_mask);
    assign wready    = awready; // Address and data accepted together
    assign irq       = irq_pending;

    // Bus handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            arready <= arvalid && !arready && !rvalid;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= addr_known(awaddr) ? 2'b00 : 2'b10; // OKAY or SLVERR
        if (rd_fire) begin
            rdata <= reg_word(araddr);
            rresp <= addr_known(araddr) ? 2'b00 : 2'b10;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
            cfg    <= '{color:       '{red_min:   DEF_RED_MIN,
                                       green_min: DEF_GREEN_MIN,
                                       green_max: DEF_GREEN_MAX,
                                       blue_max:  DEF_BLUE_MAX},
                        left_end:    DEF_LEFT_END,
                        right_start: DEF_RIGHT_START,
                        threshold:   DEF_THRESHOLD};
            status      <= '0;
            frame_cnt   <= '0;
            irq_pending <= 1'b0;
        end else begin
            if (wr_fire) begin
                case (awaddr)
                    REG_CTRL:   enable <= wr_word[0];
                    REG_COLOR:  cfg.color <= color_cfg_t'(wr_word[15:0]);
                    REG_ZONES: begin
                        cfg.left_end    <= wr_word[COL_W-1:0];
                        cfg.right_start <= wr_word[16 +: COL_W];
                    end
                    REG_THRESH: cfg.threshold <= wr_word[COUNT_W-1:0];
                    REG_IRQ: begin
                        if (wstrb[0] && wdata[0])
                            irq_pending <= 1'b0; // Write one to clear
                    end
                    default: ; // Status, count and unmapped offsets
                endcase
            end
            // A fresh result wins over a clear in the same cycle
            if (result_valid) begin
                status      <= result;
                frame_cnt   <= frame_cnt + 1'b1;
                irq_pending <= 1'b1;
            end
        end
    end

endmodule

// File: design/orange_detect_top.sv
`timescale 1ns/100ps

module orange_detect_top
    import vision_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  rgb444_t     pixel,
    input  logic        href,
    input  logic        vsync,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        irq
);

    pixel_beat_t    beat;
    logic           beat_valid;
    class_beat_t    cls;
    logic           cls_valid;
    frame_stats_t   stats;
    logic           stats_valid;
    detect_result_t result;
    logic           result_valid;
    detect_cfg_t    cfg;
    logic           enable;

    frame_timing i_frame_timing (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .pixel      (pixel),
        .href       (href),
        .vsync      (vsync),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    pixel_classifier i_pixel_classifier (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat),
        .beat_valid (beat_valid),
        .cfg        (cfg),
        .cls        (cls),
        .cls_valid  (cls_valid)
    );

    zone_accumulator i_zone_accumulator (
        .clk         (clk),
        .rst         (rst),
        .cls         (cls),
        .cls_valid   (cls_valid),
        .stats       (stats),
        .stats_valid (stats_valid)
    );

    steer_decision i_steer_decision (
        .clk          (clk),
        .rst          (rst),
        .stats        (stats),
        .stats_valid  (stats_valid),
        .threshold    (cfg.threshold),
        .result       (result),
        .result_valid (result_valid)
    );

    detect_ctrl i_detect_ctrl (
        .clk          (clk),
        .rst          (rst),
        .result       (result),
        .result_valid (result_valid),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .cfg          (cfg),
        .enable       (enable),
        .irq          (irq)
    );

endmodule

// File: verification/tb_orange_detect.sv
`timescale 1ns/100ps

module tb_orange_detect
    import vision_pkg::*;
();

    localparam int NUM_TESTS      = 9;
    localparam int FIELDS         = 12; // Hex values per stimulus entry
    localparam int LINE_GAP       = 8;  // Idle cycles between lines
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 80000 + 20000;

    logic        clk;
    logic        rst;
    rgb444_t     pixel;
    logic        href;
    logic        vsync;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        irq;

    logic [31:0] stim_mem [0:127];
    logic [31:0] lfsr        = 32'h4896;
    int          cycle_count = 0;

    orange_detect_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .pixel   (pixel),
        .href    (href),
        .vsync   (vsync),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_stop("Timeout: the run went past its cycle limit without finishing");
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] field(input int test, input int k);
        logic [6:0] idx;
        idx = 7'(test * FIELDS + k);
        return stim_mem[idx];
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_nibble(output logic [3:0] v);
        v = 4'd0;
        for (int i = 0; i < 4; i++) begin
            v    = {v[2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int rect_count(input int c0, input int c1, input int r0, input int r1);
        return (c1 - c0 + 1) * (r1 - r0 + 1);
    endfunction

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_stop($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_stop($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_result(input detect_result_t got, input detect_result_t exp);
        if (got !== exp)
            fail_stop($sformatf("Fail result: got 0x%h (det %h dir %h count %h), expected 0x%h",
                                got, got.detected, got.direction, got.orange_count, exp));
    endtask

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        next_edge;
        while (!(awready && wready))
            next_edge;
        next_edge; // Accepted on this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid)
            next_edge;
        resp = bresp;
        next_edge;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        next_edge;
        while (!arready)
            next_edge;
        next_edge;
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid)
            next_edge;
        data = rdata;
        resp = rresp;
        next_edge;
        rready = 1'b0;
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp("bresp", resp, 2'b00);
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_resp("rresp", resp, 2'b00);
    endtask

    // One full frame, orange inside the rectangle only
    task automatic send_frame(input color_cfg_t color, input int c0, input int c1,
                              input int r0, input int r1);
        rgb444_t    orange;
        logic [3:0] r;
        logic [3:0] g;
        orange = '{red: color.red_min, green: color.green_max, blue: color.blue_max};
        vsync  = 1'b1;
        next_edge;
        vsync = 1'b0;
        next_edge;
        for (int row = 0; row < FRAME_HEIGHT; row++) begin
            for (int col = 0; col < FRAME_WIDTH; col++) begin
                href = 1'b1;
                if (col >= c0 && col <= c1 && row >= r0 && row <= r1) begin
                    pixel = orange;
                end else begin
                    random_nibble(r);
                    random_nibble(g);
                    pixel = '{red: r, green: g, blue: color.blue_max + 4'd1}; // Never orange
                end
                next_edge;
            end
            href  = 1'b0;
            pixel = '0;
            repeat (LINE_GAP) next_edge;
        end
    endtask

    initial begin
        detect_result_t exp_res;
        detect_result_t got_res;
        color_cfg_t     color;
        logic [31:0]    st;
        logic [31:0]    cnt;
        logic [31:0]    word;
        logic [31:0]    last_status;
        logic [1:0]     resp;
        int             exp_frames;
        int             count;

        rst     = 1'b1;
        pixel   = '0;
        href    = 1'b0;
        vsync   = 1'b0;
        awaddr  = 5'd0;
        awvalid = 1'b0;
        wdata   = 32'd0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = 5'd0;
        arvalid = 1'b0;
        rready  = 1'b0;

        foreach (stim_mem[i])
            stim_mem[i] = '1; // Marks entries the file leaves unset
        $readmemh("verification/orange_stimulus.txt", stim_mem);
        if (field(NUM_TESTS - 1, FIELDS - 1) === 32'hFFFF_FFFF)
            fail_stop("The stimulus file could not be read or holds too few entries");

        repeat (8) next_edge;
        rst = 1'b0;
        next_edge;

        // Values right after reset
        if (irq)
            fail_stop("irq is high right after reset");
        reg_read(REG_STATUS, word);
        check_word("REG_STATUS", word, 32'h0);
        reg_read(REG_COUNT, word);
        check_word("REG_COUNT", word, 32'h0);
        reg_read(REG_CTRL, word);
        check_word("REG_CTRL", word, 32'h1);
        reg_read(REG_COLOR, word);
        check_word("REG_COLOR", word, 32'h0000_C493);
        reg_read(REG_ZONES, word);
        check_word("REG_ZONES", word, 32'h010E_0064);
        reg_read(REG_THRESH, word);
        check_word("REG_THRESH", word, 32'h0000_0F00);
        reg_read(REG_IRQ, word);
        check_word("REG_IRQ", word, 32'h0);

        exp_frames  = 0;
        last_status = 32'h0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            color = color_cfg_t'(16'(field(t, 1)));
            count = rect_count(int'(field(t, 5)), int'(field(t, 6)),
                               int'(field(t, 7)), int'(field(t, 8)));
            if (count != int'(field(t, 11)))
                fail_stop($sformatf(
                    "Stimulus entry %0d has a count that its rectangle does not give", t));
            if ((count > int'(field(t, 4))) != (field(t, 9) == 32'd1))
                fail_stop($sformatf("Stimulus entry %0d disagrees with its threshold", t));

            reg_write(REG_CTRL, field(t, 0));
            reg_write(REG_COLOR, field(t, 1));
            reg_write(REG_ZONES, {7'd0, 9'(field(t, 3)), 7'd0, 9'(field(t, 2))});
            reg_write(REG_THRESH, field(t, 4));
            send_frame(color, int'(field(t, 5)), int'(field(t, 6)),
                       int'(field(t, 7)), int'(field(t, 8)));

            if (field(t, 0) == 32'd0) begin
                // Disabled frame leaves the result and counter alone
                repeat (20) next_edge;
                if (irq)
                    fail_stop("irq rose for a frame sent while detection was disabled");
                reg_read(REG_STATUS, st);
                check_word("REG_STATUS", st, last_status);
            end else begin
                exp_frames++;
                while (!irq)
                    next_edge;
                reg_read(REG_STATUS, st);
                reg_read(REG_COUNT, cnt);
                exp_res = '{detected:     1'(field(t, 9)),
                            direction:    3'(field(t, 10)),
                            orange_count: COUNT_W'(field(t, 11))};
                got_res = '{detected: st[0], direction: st[3:1], orange_count: cnt[COUNT_W-1:0]};
                check_result(got_res, exp_res);
                check_word("REG_COUNT", cnt, 32'(count));
                check_word("REG_STATUS frame counter", {16'd0, st[31:16]}, 32'(exp_frames));
                last_status = st;

                reg_read(REG_IRQ, word);
                check_word("REG_IRQ", word, 32'h1);
                reg_write(REG_IRQ, 32'h0);
                if (!irq)
                    fail_stop("irq dropped after a write of 0 to REG_IRQ");
                reg_write(REG_IRQ, 32'h1);
                if (irq)
                    fail_stop("irq stayed high after a write of 1 to REG_IRQ");
            end
        end

        // Read-only status ignores writes
        axi_write(REG_STATUS, 32'hFFFF_FFFF, resp);
        check_resp("bresp", resp, 2'b00);
        reg_read(REG_STATUS, st);
        check_word("REG_STATUS", st, last_status);

        axi_read(5'h1C, word, resp);
        check_resp("rresp", resp, 2'b10); // SLVERR
        axi_write(5'h1C, 32'h1234_5678, resp);
        check_resp("bresp", resp, 2'b10);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verification/orange_stimulus.txt
// enable color left_end right_start threshold col_first col_last row_first row_last det dir count
// All hex; color nibbles are red_min green_min green_max blue_max
// Right zone, default bounds
1 C493 064 10E 00F00 118 13F 000 077 1 2 012C0
// Count equal to threshold, direction held
1 C493 064 10E 00064 000 009 000 009 0 2 00064
// Centre zone
1 C493 064 10E 00F00 078 0DB 032 063 1 3 01388
// Left equals right, centre smaller, direction held
1 C493 078 0C8 00F00 000 13F 000 027 1 3 03200
// Left zone
1 C493 064 10E 00F00 000 04F 000 03B 1 1 012C0
// Centre rectangle moved right by new zone bounds
1 C493 00A 064 00F00 078 0DB 032 063 1 2 01388
// Other colour window, threshold one below the count
1 82A6 064 10E 01387 078 0DB 032 063 1 3 01388
// Detection disabled, result columns give what the frame would produce
0 C493 064 10E 00F00 118 13F 000 077 1 2 012C0
// Right wins over a larger centre
1 C493 064 10E 00F00 0C8 13F 064 08B 1 2 012C0

// File: compile.f
design/vision_pkg.sv
design/frame_timing.sv
design/pixel_classifier.sv
design/zone_accumulator.sv
design/steer_decision.sv
design/detect_ctrl.sv
design/orange_detect_top.sv
verification/tb_orange_detect.sv

// File: Makefile
TOP := tb_orange_detect

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): compile.f design/*.sv verification/*.sv
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module orange_detect_top

clean:
	rm -rf obj_dir
